// ==== filelist.f ====
+incdir+hdl
hdl/jpeg_stuff_pkg.sv
hdl/ff_stuff_pipeline.sv
hdl/stuff_fifo.sv
hdl/word_repacker.sv
hdl/ff_byte_stuffer.sv
verification/tb_clock_gen.sv
verification/ff_byte_stuffer_checker.sv
verification/ff_byte_stuffer_tb.sv

// ==== hdl/ff_byte_stuffer.sv ====
`timescale 1ns/1ps

module ff_byte_stuffer (
	input logic clk,
	input logic rst,
	input jpeg_stuff_pkg::jpeg_word_t data_in,
	input logic data_ready_in,
	output jpeg_stuff_pkg::jpeg_word_t jpeg_out,
	output logic data_ready
);

	jpeg_stuff_pkg::stuffed_chunk_t chunk;
	jpeg_stuff_pkg::stuffed_chunk_t rd_chunk;
	logic chunk_valid;
	logic pop;
	logic rd_valid;
	logic empty;

	ff_stuff_pipeline ff_stuff_pipeline_inst (
		.clk(clk),
		.rst(rst),
		.data_in(data_in),
		.data_ready_in(data_ready_in),
		.chunk(chunk),
		.chunk_valid(chunk_valid)
	);

	// absorbs the extra bytes while the repacker drains one word per cycle
	stuff_fifo stuff_fifo_inst (
		.clk(clk),
		.rst(rst),
		.wr_chunk(chunk),
		.wr_en(chunk_valid),
		.pop(pop),
		.rd_chunk(rd_chunk),
		.rd_valid(rd_valid),
		.empty(empty)
	);

	word_repacker word_repacker_inst (
		.clk(clk),
		.rst(rst),
		.rd_chunk(rd_chunk),
		.rd_valid(rd_valid),
		.empty(empty),
		.pop(pop),
		.jpeg_out(jpeg_out),
		.data_ready(data_ready)
	);

endmodule

// ==== hdl/ff_stuff_pipeline.sv ====
`timescale 1ns/1ps
`include "jpeg_stuff_consts.svh"

module ff_stuff_pipeline (
	input logic clk,
	input logic rst,
	input jpeg_stuff_pkg::jpeg_word_t data_in,
	input logic data_ready_in,
	output jpeg_stuff_pkg::stuffed_chunk_t chunk,
	output logic chunk_valid
);

	localparam int word_bytes = `JPEG_WORD_BYTES;
	localparam int max_bytes = `STUFF_MAX_BYTES;
	localparam jpeg_stuff_pkg::byte_count_t word_count = jpeg_stuff_pkg::byte_count_t'(word_bytes);

	// stage 0 holds the registered word and stages 1 to 4 each resolve one byte position
	jpeg_stuff_pkg::stuffed_chunk_t stage_chunk [0:word_bytes];
	logic [word_bytes:0] stage_valid;

	// one marker flag per input byte where bit word_bytes-1 belongs to the first byte
	logic [word_bytes-1:0] stage_flags [0:word_bytes-1];

	function automatic logic is_marker(input jpeg_stuff_pkg::jpeg_byte_t b);
		return b == `JPEG_MARKER_BYTE;
	endfunction

	// inserts a stuff byte right after byte pos, counted from the left,
	// and moves every later byte one place to the right
	function automatic jpeg_stuff_pkg::stuffed_bytes_t insert_stuff(
		input jpeg_stuff_pkg::stuffed_bytes_t bytes_in,
		input jpeg_stuff_pkg::byte_count_t pos
	);
		jpeg_stuff_pkg::stuffed_bytes_t bytes_out;
		bytes_out = bytes_in;
		for (int i = 1; i < max_bytes; i++) begin
			if (i == pos + 1)
				bytes_out[(max_bytes - i) * 8 - 1 -: 8] = `JPEG_STUFF_BYTE;
			else if (i > pos + 1)
				bytes_out[(max_bytes - i) * 8 - 1 -: 8] = bytes_in[(max_bytes - i + 1) * 8 - 1 -: 8];
		end
		return bytes_out;
	endfunction

	// the strobe walks beside the data so that several words can be in flight
	always_ff @(posedge clk) begin
		if (rst)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[word_bytes-1:0], data_ready_in};
	end

	// stage 0 places the word at the left of the chunk and flags the marker bytes
	always_ff @(posedge clk) begin
		if (data_ready_in) begin
			stage_chunk[0].bytes <= {data_in, {(max_bytes - word_bytes) * 8{1'b0}}};
			stage_chunk[0].count <= word_count;
			for (int i = 0; i < word_bytes; i++) begin
				stage_flags[0][i] <= is_marker(data_in[i*8 +: 8]);
			end
		end
	end

	for (genvar s = 1; s <= word_bytes; s++) begin : g_stage
		// original byte s-1 has moved right by one place for every stuff byte before it
		jpeg_stuff_pkg::byte_count_t pos;

		assign pos = jpeg_stuff_pkg::byte_count_t'(s - 1) + stage_chunk[s-1].count - word_count;

		always_ff @(posedge clk) begin
			if (stage_valid[s-1]) begin
				if (stage_flags[s-1][word_bytes-s]) begin
					stage_chunk[s].bytes <= insert_stuff(stage_chunk[s-1].bytes, pos);
					stage_chunk[s].count <= stage_chunk[s-1].count + 1'b1;
				end else begin
					stage_chunk[s] <= stage_chunk[s-1];
				end
			end
		end

		// the last stage has no later positions left to flag
		if (s < word_bytes) begin : g_flags
			always_ff @(posedge clk) begin
				if (stage_valid[s-1])
					stage_flags[s] <= stage_flags[s-1];
			end
		end
	end

	assign chunk = stage_chunk[word_bytes];
	assign chunk_valid = stage_valid[word_bytes];

	// every chunk that leaves the pipeline holds four to eight bytes
	a_chunk_count: assert property (
		@(posedge clk) disable iff (rst)
		chunk_valid |-> (chunk.count >= word_count &&
			chunk.count <= jpeg_stuff_pkg::byte_count_t'(max_bytes))
	) else $error("stuffed chunk byte count out of range");

	// stuffing can double the data, so input strobes may not come back to back
	a_strobe_spacing: assert property (
		@(posedge clk) disable iff (rst)
		data_ready_in |=> !data_ready_in
	) else $error("data_ready_in high on two adjacent cycles");

endmodule

// ==== hdl/jpeg_stuff_consts.svh ====
`ifndef JPEG_STUFF_CONSTS_SVH
`define JPEG_STUFF_CONSTS_SVH

// bytes in one entropy-coded input word and in one packed output word
`define JPEG_WORD_BYTES 4

// a marker byte in the coded data must be followed by a stuffed zero byte
`define JPEG_MARKER_BYTE 8'hFF
`define JPEG_STUFF_BYTE 8'h00

// default number of stuffed chunks the FIFO can hold
`define STUFF_FIFO_DEPTH 16

// an input word of four marker bytes grows to eight bytes
`define STUFF_MAX_BYTES 8

// three bytes still held plus one full chunk of eight
`define REPACK_MAX_BYTES 11

`endif

// ==== hdl/jpeg_stuff_pkg.sv ====
`include "jpeg_stuff_consts.svh"

package jpeg_stuff_pkg;

	// one byte of the coded stream
	typedef logic [7:0] jpeg_byte_t;

	// one input or output word, first byte in the top bits
	typedef logic [`JPEG_WORD_BYTES*8-1:0] jpeg_word_t;

	// bytes of one word after stuffing, left-aligned with zeros behind the last valid byte
	typedef logic [`STUFF_MAX_BYTES*8-1:0] stuffed_bytes_t;

	// byte count wide enough for the repacker accumulator
	typedef logic [3:0] byte_count_t;

	// one FIFO entry
	// count is the number of valid bytes at the left of bytes, from four to eight
	typedef struct packed {
		stuffed_bytes_t bytes;
		byte_count_t count;
	} stuffed_chunk_t;

endpackage

// ==== hdl/stuff_fifo.sv ====
`timescale 1ns/1ps
`include "jpeg_stuff_consts.svh"

module stuff_fifo #(
	parameter int depth = `STUFF_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input jpeg_stuff_pkg::stuffed_chunk_t wr_chunk,
	input logic wr_en,
	input logic pop,
	output jpeg_stuff_pkg::stuffed_chunk_t rd_chunk,
	output logic rd_valid,
	output logic empty
);

	localparam int ptr_width = $clog2(depth);

	jpeg_stuff_pkg::stuffed_chunk_t mem [0:depth-1];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width:0] fill;
	logic full;
	logic do_write;
	logic do_read;

	assign empty = (fill == '0);
	assign full = (fill == (ptr_width + 1)'(depth));
	assign do_write = wr_en && !full;
	assign do_read = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= wr_chunk;
		if (do_read)
			rd_chunk <= mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// a simultaneous write and read leave the fill level unchanged
			case ({do_write, do_read})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			rd_valid <= do_read;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
		else $error("write to a full stuffing FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("pop from an empty stuffing FIFO");

endmodule

// ==== hdl/word_repacker.sv ====
`timescale 1ns/1ps
`include "jpeg_stuff_consts.svh"

module word_repacker (
	input logic clk,
	input logic rst,
	input jpeg_stuff_pkg::stuffed_chunk_t rd_chunk,
	input logic rd_valid,
	input logic empty,
	output logic pop,
	output jpeg_stuff_pkg::jpeg_word_t jpeg_out,
	output logic data_ready
);

	localparam int acc_bits = `REPACK_MAX_BYTES * 8;
	localparam int pad_bits = (`REPACK_MAX_BYTES - `STUFF_MAX_BYTES) * 8;
	localparam int word_bits = `JPEG_WORD_BYTES * 8;
	localparam jpeg_stuff_pkg::byte_count_t word_count =
		jpeg_stuff_pkg::byte_count_t'(`JPEG_WORD_BYTES);

	// held bytes sit at the left of the accumulator, oldest byte first
	logic [acc_bits-1:0] acc;
	logic [acc_bits-1:0] acc_kept;
	logic [acc_bits-1:0] acc_next;
	logic [acc_bits-1:0] chunk_aligned;
	logic [acc_bits-1:0] keep_mask;
	jpeg_stuff_pkg::byte_count_t held;
	jpeg_stuff_pkg::byte_count_t held_kept;
	jpeg_stuff_pkg::byte_count_t held_next;
	logic emit;

	// four or more held bytes always leave as one word this cycle
	assign emit = (held >= word_count);
	assign acc_kept = emit ? acc << word_bits : acc;
	assign held_kept = emit ? held - word_count : held;

	// the pop decision looks at what is left after this cycle's word,
	// so a new chunk can be fetched while the last full word goes out.
	// While rd_valid is high the returning chunk is not counted yet
	assign pop = !empty && !rd_valid && (held_kept < word_count);

	// new bytes go right behind the kept ones
	assign chunk_aligned = {rd_chunk.bytes, {pad_bits{1'b0}}} >> {held_kept, 3'b000};
	assign keep_mask = ~({acc_bits{1'b1}} >> {held_kept, 3'b000});

	always_comb begin
		acc_next = acc_kept;
		held_next = held_kept;
		if (rd_valid) begin
			acc_next = (acc_kept & keep_mask) | chunk_aligned;
			held_next = held_kept + rd_chunk.count;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= '0;
			data_ready <= 1'b0;
		end else begin
			held <= held_next;
			data_ready <= emit;
		end
	end

	always_ff @(posedge clk) begin
		acc <= acc_next;
		if (emit)
			jpeg_out <= acc[acc_bits-1 -: word_bits];
	end

	a_held_limit: assert property (
		@(posedge clk) disable iff (rst)
		held <= jpeg_stuff_pkg::byte_count_t'(`REPACK_MAX_BYTES)
	) else $error("repacker holds more bytes than the accumulator can take");

	// a chunk may only come back from the FIFO when there is room for a full one
	a_room_on_return: assert property (
		@(posedge clk) disable iff (rst)
		rd_valid |-> held < word_count
	) else $error("chunk returned while a full word is still held");

endmodule

// ==== verification/ff_byte_stuffer_checker.sv ====
`timescale 1ns/1ps
`include "jpeg_stuff_consts.svh"

module ff_byte_stuffer_checker #(
	parameter int stim_timeout = 5000,
	parameter int drain_timeout = 200,
	parameter int settle_cycles = 10
) (
	input logic clk,
	input logic rst,
	input jpeg_stuff_pkg::jpeg_word_t data_in,
	input logic data_ready_in,
	input jpeg_stuff_pkg::jpeg_word_t jpeg_out,
	input logic data_ready,
	input logic stim_done,
	output logic check_done,
	output int mismatch_count,
	output int error_count
);

	// bytes the DUT still owes, oldest first
	jpeg_stuff_pkg::jpeg_byte_t expected_bytes[$];

	// reference model: every input byte in order, with a zero byte after each marker
	function automatic void append_stuffed(input jpeg_stuff_pkg::jpeg_word_t word);
		jpeg_stuff_pkg::jpeg_byte_t b;
		for (int i = `JPEG_WORD_BYTES - 1; i >= 0; i--) begin
			b = word[i*8 +: 8];
			expected_bytes.push_back(b);
			if (b == 8'hFF)
				expected_bytes.push_back(8'h00);
		end
	endfunction

	// all inputs change on the falling edge and all outputs are registered,
	// so the rising edge sees both sides settled
	always @(posedge clk) begin
		jpeg_stuff_pkg::jpeg_word_t expected;
		if (rst) begin
			if (data_ready === 1'b1) begin
				error_count++;
				$display("data_ready went high during reset at %0t", $time);
			end
		end else begin
			if (data_ready_in === 1'b1)
				append_stuffed(data_in);
			if (data_ready === 1'b1) begin
				if (expected_bytes.size() < `JPEG_WORD_BYTES) begin
					error_count++;
					$display("data_ready at %0t with only %0d bytes expected",
						$time, expected_bytes.size());
				end else begin
					expected = {expected_bytes[0], expected_bytes[1],
						expected_bytes[2], expected_bytes[3]};
					repeat (`JPEG_WORD_BYTES) void'(expected_bytes.pop_front());
					if (jpeg_out !== expected) begin
						mismatch_count++;
						$display("MISMATCH time=%0t signal=jpeg_out expected=%h actual=%h",
							$time, expected, jpeg_out);
					end
				end
			end else if (data_ready !== 1'b0) begin
				error_count++;
				$display("data_ready is unknown at %0t", $time);
			end
		end
	end

	initial begin
		int wait_cycles;
		check_done = 1'b0;
		mismatch_count = 0;
		error_count = 0;
		wait_cycles = 0;
		while (stim_done !== 1'b1 && wait_cycles < stim_timeout) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (stim_done !== 1'b1) begin
			error_count++;
			$display("stimulus did not finish within %0d cycles", stim_timeout);
		end
		// a whole word still owed must come out
		wait_cycles = 0;
		while (expected_bytes.size() >= `JPEG_WORD_BYTES && wait_cycles < drain_timeout) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (expected_bytes.size() >= `JPEG_WORD_BYTES) begin
			error_count++;
			$display("output did not drain, %0d bytes still expected", expected_bytes.size());
		end
		// a few more cycles catch any stray word after the drain
		repeat (settle_cycles) @(posedge clk);
		check_done = 1'b1;
	end

endmodule

// ==== verification/ff_byte_stuffer_tb.sv ====
`timescale 1ns/1ps

module ff_byte_stuffer_tb;

	localparam logic [15:0] seed = 16'd31393;
	localparam int reset_timeout = 20;
	localparam int finish_timeout = 400;
	localparam int idle_cycles = 20;
	localparam int random_words = 300;

	logic clk;
	logic rst;
	jpeg_stuff_pkg::jpeg_word_t data_in;
	logic data_ready_in;
	jpeg_stuff_pkg::jpeg_word_t jpeg_out;
	logic data_ready;
	logic stim_done;
	logic check_done;
	int mismatch_count;
	int error_count;
	logic [15:0] lfsr_state;

	tb_clock_gen #(.period(100), .reset_cycles(5)) tb_clock_gen_inst (
		.clk(clk),
		.rst(rst)
	);

	ff_byte_stuffer ff_byte_stuffer_inst (
		.clk(clk),
		.rst(rst),
		.data_in(data_in),
		.data_ready_in(data_ready_in),
		.jpeg_out(jpeg_out),
		.data_ready(data_ready)
	);

	ff_byte_stuffer_checker ff_byte_stuffer_checker_inst (
		.clk(clk),
		.rst(rst),
		.data_in(data_in),
		.data_ready_in(data_ready_in),
		.jpeg_out(jpeg_out),
		.data_ready(data_ready),
		.stim_done(stim_done),
		.check_done(check_done),
		.mismatch_count(mismatch_count),
		.error_count(error_count)
	);

	// a 16-bit Galois LFSR steps once for every bit taken and the first bit ends up at the top
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] bits;
		logic out;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			out = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out)
				lfsr_state = lfsr_state ^ 16'hB400;
			bits = {bits[6:0], out};
		end
		return bits;
	endfunction

	// roughly one byte in four is a marker
	function automatic jpeg_stuff_pkg::jpeg_byte_t random_byte();
		if (take_bits(2) == 8'd3)
			return 8'hFF;
		return take_bits(8);
	endfunction

	// the strobe lasts one cycle and the next one comes gap cycles later
	task automatic send_word(input jpeg_stuff_pkg::jpeg_word_t word, input int gap);
		@(negedge clk);
		data_in = word;
		data_ready_in = 1'b1;
		@(negedge clk);
		data_ready_in = 1'b0;
		repeat (gap - 2) @(negedge clk);
	endtask

	initial begin
		int n;
		int timeout_count;
		jpeg_stuff_pkg::jpeg_word_t word;
		data_in = '0;
		data_ready_in = 1'b0;
		stim_done = 1'b0;
		lfsr_state = seed;
		timeout_count = 0;
		n = 0;
		while (rst !== 1'b0 && n < 5 * reset_timeout) begin
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			timeout_count++;
			$display("reset was not released within %0d cycles", 5 * reset_timeout);
		end
		// no input yet, so no word may appear
		repeat (idle_cycles) @(negedge clk);
		for (int i = 0; i < 6; i++)
			send_word(32'h01020304 + i * 32'h10101010, 3);
		send_word(32'hFF112233, 2);
		send_word(32'h44FF5566, 2);
		send_word(32'h7788FF99, 2);
		send_word(32'hAABBCCFF, 2);
		for (int i = 0; i < 3; i++)
			send_word(32'hFFFFFFFF, 3);
		for (int i = 0; i < random_words; i++) begin
			word = '0;
			for (int b = 0; b < 4; b++)
				word = {word[23:0], random_byte()};
			send_word(word, 2 + int'(take_bits(2)));
		end
		stim_done = 1'b1;
		n = 0;
		while (check_done !== 1'b1 && n < finish_timeout) begin
			@(negedge clk);
			n++;
		end
		if (check_done !== 1'b1) begin
			timeout_count++;
			$display("timed out waiting for the checker to finish");
		end
		$display("checks done: %0d mismatches, %0d other errors", mismatch_count,
			error_count + timeout_count);
		if (check_done === 1'b1 && mismatch_count == 0 && error_count + timeout_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter realtime period = 100,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset is released on a falling edge, like every other DUT input
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule
